// ==== Makefile ====
# Verilator build and run for the NES host glue testbench

VERILATOR ?= verilator
TOP       ?= tb_nes_host
FILELIST  ?= nes_host_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then echo "simulator exited with status $$status"; exit 1; fi
	@if grep -q "CHECKS FAILED" $(LOG); then \
	  echo "simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== logic/host_reg_bank.sv ====
// Host register bank
// config and button registers plus the ROM loader byte stream,
// each loaded byte goes out as a one-cycle write at the next address
`timescale 1ns/1ps

module host_reg_bank import nes_host_pkg::*; (
  input  logic         clk,
  input  logic         sys_resetn,
  input  reg_write_t   i_reg,
  output load_wr_t     o_load,
  output logic         o_nes_reset,
  output nes_buttons_t o_btn0,
  output nes_buttons_t o_btn1
);

  logic                  conf_reset_q; // only the reset bit of config is defined
  nes_buttons_t          btn0_q;
  nes_buttons_t          btn1_q;
  logic [MEM_ADDR_W-1:0] load_addr_q;
  logic                  load_valid_q;
  logic [MEM_ADDR_W-1:0] load_out_addr_q;
  logic [DATA_W-1:0]     load_out_data_q;

  logic wr_conf;
  logic wr_load;
  logic rewind;

  assign wr_conf = i_reg.strobe && (i_reg.addr == REG_CONF);
  assign wr_load = i_reg.strobe && (i_reg.addr == REG_LOAD);
  // reset bit going 0 to 1 restarts the stream at address 0
  assign rewind  = wr_conf && i_reg.data[CONF_RESET_BIT] && !conf_reset_q;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      conf_reset_q <= 1'b1; // NES starts held in reset
      btn0_q       <= '0;
      btn1_q       <= '0;
      load_addr_q  <= '0;
      load_valid_q <= 1'b0;
    end else begin
      load_valid_q <= wr_load;
      if (wr_conf)
        conf_reset_q <= i_reg.data[CONF_RESET_BIT];
      if (i_reg.strobe && (i_reg.addr == REG_BTN0))
        btn0_q <= nes_buttons_t'(i_reg.data);
      if (i_reg.strobe && (i_reg.addr == REG_BTN1))
        btn1_q <= nes_buttons_t'(i_reg.data);
      if (rewind)
        load_addr_q <= '0;
      else if (wr_load)
        load_addr_q <= load_addr_q + 1'b1; // post increment
    end
  end

  // payload of the loader pulse
  always_ff @(posedge clk) begin
    if (wr_load) begin
      load_out_addr_q <= load_addr_q;
      load_out_data_q <= i_reg.data;
    end
  end

  assign o_load      = '{valid: load_valid_q, addr: load_out_addr_q, data: load_out_data_q};
  assign o_nes_reset = conf_reset_q;
  assign o_btn0      = btn0_q;
  assign o_btn1      = btn1_q;

endmodule

// ==== logic/joypad_port.sv ====
// NES controller port
// latches host and pad buttons while strobe is high, then shifts
// them out lsb first on falling edges of the port clock
`timescale 1ns/1ps

module joypad_port import nes_host_pkg::*; (
  input  logic         clk,
  input  logic         sys_resetn,
  input  nes_buttons_t i_host_btn,
  input  nes_buttons_t i_pad_btn,
  input  logic         i_strobe,
  input  logic         i_port_clock,
  output logic         o_data
);

  logic [7:0]   shift_q;
  logic         port_clock_q;
  nes_buttons_t merged;
  logic         clock_fall;

  assign merged     = i_host_btn | i_pad_btn;       // either source presses
  assign clock_fall = port_clock_q && !i_port_clock;

  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      shift_q      <= '0;
      port_clock_q <= 1'b0;
    end else begin
      port_clock_q <= i_port_clock;
      if (i_strobe)
        shift_q <= merged;                  // reload every cycle of strobe
      else if (clock_fall)
        shift_q <= {1'b0, shift_q[7:1]};    // zero fill after the last button
    end
  end

  assign o_data = shift_q[0];

endmodule

// ==== logic/mem_slot_arbiter.sv ====
// Memory slot arbiter
// five-phase slot cycle shared by the ROM loader and the NES core,
// loader writes win at any time, NES accesses go out at PHASE_MEM
// and read data is steered to the CPU or PPU register one cycle later
`timescale 1ns/1ps

module mem_slot_arbiter import nes_host_pkg::*; (
  input  logic              clk,
  input  logic              sys_resetn,
  input  logic              i_nes_reset,
  input  load_wr_t          i_load,
  input  mem_req_t          i_nes_req,
  input  logic [DATA_W-1:0] i_ram_rdata,
  output ram_cmd_t          o_ram,
  output logic              o_nes_run,
  output logic [DATA_W-1:0] o_cpu_rdata,
  output logic [DATA_W-1:0] o_ppu_rdata
);

  logic [PHASE_W-1:0] phase_q;
  logic               nes_grant;
  logic               nes_slot; // NES actually owns the RAM this cycle
  logic               pend_cpu_q;
  logic               pend_ppu_q;
  logic [DATA_W-1:0]  cpu_rdata_q;
  logic [DATA_W-1:0]  ppu_rdata_q;

  // phase 0 issue, 1 ram data back, 2 captured, 4 run
  always_ff @(posedge clk) begin
    if (!sys_resetn)
      phase_q <= '0;
    else if (phase_q == PHASE_W'(NUM_PHASES - 1))
      phase_q <= '0;
    else
      phase_q <= phase_q + 1'b1;
  end

  assign nes_grant = (phase_q == PHASE_MEM) && !i_nes_reset;
  assign nes_slot  = nes_grant && !i_load.valid;

  // command mux, loader first
  always_comb begin
    if (i_load.valid) begin
      o_ram.we   = 1'b1;
      o_ram.addr = i_load.addr[RAM_ADDR_W-1:0];
      o_ram.data = i_load.data;
    end else begin
      o_ram.we   = nes_grant && i_nes_req.wr;
      o_ram.addr = i_nes_req.addr[RAM_ADDR_W-1:0]; // aliases mod 1024
      o_ram.data = i_nes_req.wdata;
    end
  end

  // remember the read kind, cpu over ppu when both are set
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      pend_cpu_q <= 1'b0;
      pend_ppu_q <= 1'b0;
    end else begin
      pend_cpu_q <= nes_slot && i_nes_req.rd_cpu;
      pend_ppu_q <= nes_slot && i_nes_req.rd_ppu && !i_nes_req.rd_cpu;
    end
  end

  // each register holds until the next read of its kind
  always_ff @(posedge clk) begin
    if (!sys_resetn) begin
      cpu_rdata_q <= '0;
      ppu_rdata_q <= '0;
    end else begin
      if (pend_cpu_q)
        cpu_rdata_q <= i_ram_rdata;
      if (pend_ppu_q)
        ppu_rdata_q <= i_ram_rdata;
    end
  end

  assign o_nes_run   = (phase_q == PHASE_RUN) && !i_nes_reset;
  assign o_cpu_rdata = cpu_rdata_q;
  assign o_ppu_rdata = ppu_rdata_q;

endmodule

// ==== logic/nes_host_pkg.sv ====
// NES host glue shared definitions
// widths, host register map, slot phases and the bus structs
package nes_host_pkg;

  localparam int MEM_ADDR_W = 22; // 4 MB NES address space
  localparam int RAM_ADDR_W = 10; // work RAM decodes only the low bits
  localparam int DATA_W     = 8;

  localparam int NUM_PHASES = 5;
  localparam int PHASE_W    = $clog2(NUM_PHASES);
  localparam logic [PHASE_W-1:0] PHASE_MEM = 0; // NES access issued here
  localparam logic [PHASE_W-1:0] PHASE_RUN = 4; // NES advanced here

  // host register addresses
  localparam logic [7:0] REG_CONF = 8'h35;
  localparam logic [7:0] REG_LOAD = 8'h37;
  localparam logic [7:0] REG_BTN0 = 8'h40;
  localparam logic [7:0] REG_BTN1 = 8'h41;

  localparam int CONF_RESET_BIT = 0; // holds NES in reset, rewinds loader

  // a is bit 0 and leaves the pad first
  typedef struct packed {
    logic right;
    logic left;
    logic down;
    logic up;
    logic start;
    logic select;
    logic b;
    logic a;
  } nes_buttons_t;

  typedef struct packed {
    logic              strobe;
    logic [7:0]        addr;
    logic [DATA_W-1:0] data;
  } reg_write_t;

  typedef struct packed {
    logic                  rd_cpu;
    logic                  rd_ppu;
    logic                  wr;
    logic [MEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
  } mem_req_t;

  typedef struct packed {
    logic                  we;
    logic [RAM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     data;
  } ram_cmd_t;

  typedef struct packed {
    logic                  valid;
    logic [MEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     data;
  } load_wr_t;

endpackage

// ==== logic/nes_host_top.sv ====
// NES host glue top level
// host register bank, two joypad ports and the slot arbiter around
// the work RAM that the loader and the NES core share
`timescale 1ns/1ps

module nes_host_top import nes_host_pkg::*; (
  input  logic              clk,
  input  logic              sys_resetn,
  input  reg_write_t        i_reg,
  input  mem_req_t          i_nes_req,
  input  nes_buttons_t      i_pad_btn0,
  input  nes_buttons_t      i_pad_btn1,
  input  logic              i_joy_strobe,
  input  logic [1:0]        i_joy_clock,
  output logic [1:0]        o_joy_data,
  output logic              o_nes_run,
  output logic              o_nes_reset,
  output logic [DATA_W-1:0] o_cpu_rdata,
  output logic [DATA_W-1:0] o_ppu_rdata
);

  load_wr_t          load_wr;
  nes_buttons_t      host_btn0;
  nes_buttons_t      host_btn1;
  ram_cmd_t          ram_cmd;
  logic [DATA_W-1:0] ram_rdata;

  host_reg_bank u_regs (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .i_reg      (i_reg),
    .o_load     (load_wr),
    .o_nes_reset(o_nes_reset),
    .o_btn0     (host_btn0),
    .o_btn1     (host_btn1)
  );

  joypad_port u_joy0 ( // player 1
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .i_host_btn  (host_btn0),
    .i_pad_btn   (i_pad_btn0),
    .i_strobe    (i_joy_strobe),
    .i_port_clock(i_joy_clock[0]),
    .o_data      (o_joy_data[0])
  );

  joypad_port u_joy1 ( // player 2
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .i_host_btn  (host_btn1),
    .i_pad_btn   (i_pad_btn1),
    .i_strobe    (i_joy_strobe),
    .i_port_clock(i_joy_clock[1]),
    .o_data      (o_joy_data[1])
  );

  mem_slot_arbiter u_arb (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .i_nes_reset(o_nes_reset),
    .i_load     (load_wr),
    .i_nes_req  (i_nes_req),
    .i_ram_rdata(ram_rdata),
    .o_ram      (ram_cmd),
    .o_nes_run  (o_nes_run),
    .o_cpu_rdata(o_cpu_rdata),
    .o_ppu_rdata(o_ppu_rdata)
  );

  work_ram u_ram (
    .clk    (clk),
    .i_cmd  (ram_cmd),
    .o_rdata(ram_rdata)
  );

endmodule

// ==== logic/work_ram.sv ====
// Work RAM
// byte-wide synchronous memory shared by the loader and the NES core,
// read data follows the address by one cycle, old data on a write
`timescale 1ns/1ps

module work_ram import nes_host_pkg::*; (
  input  logic              clk,
  input  ram_cmd_t          i_cmd,
  output logic [DATA_W-1:0] o_rdata
);

  localparam int DEPTH = 2 ** RAM_ADDR_W;

  logic [DATA_W-1:0] mem [DEPTH];
  logic [DATA_W-1:0] rdata_q;

  always_ff @(posedge clk) begin
    if (i_cmd.we)
      mem[i_cmd.addr] <= i_cmd.data;
    rdata_q <= mem[i_cmd.addr]; // read every cycle
  end

  assign o_rdata = rdata_q;

endmodule

// ==== nes_host_top.f ====
logic/nes_host_pkg.sv
logic/host_reg_bank.sv
logic/joypad_port.sv
logic/mem_slot_arbiter.sv
logic/work_ram.sv
logic/nes_host_top.sv
verification/nes_host_chk.sv
verification/nes_host_monitor.sv
verification/tb_nes_host.sv

// ==== verification/nes_host_chk.sv ====
// slot arbiter assertions
// run pulse placement and spacing, no NES access while held in reset
`timescale 1ns/1ps

module nes_host_chk import nes_host_pkg::*; (
  input logic               clk,
  input logic               sys_resetn,
  input logic [PHASE_W-1:0] i_phase,
  input logic               i_nes_reset,
  input logic               i_load_valid,
  input logic               i_ram_we,
  input logic               i_rd_pending,
  input logic               i_nes_run
);

  int fail_count = 0; // failed assertions, read by the testbench

  // the access phase lies four cycles before each run pulse
  a_run_at_phase: assert property (@(posedge clk) disable iff (!sys_resetn)
    i_nes_run |-> ($past(i_phase, 4) == PHASE_MEM))
    else begin
      fail_count++;
      $error("run pulse not four cycles after the access phase");
    end

  a_no_write_in_reset: assert property (@(posedge clk) disable iff (!sys_resetn)
    (i_nes_reset && !i_load_valid) |-> !i_ram_we)
    else begin
      fail_count++;
      $error("NES write reached the RAM while held in reset");
    end

  a_no_read_in_reset: assert property (@(posedge clk) disable iff (!sys_resetn)
    i_nes_reset |=> !i_rd_pending)
    else begin
      fail_count++;
      $error("NES read issued while held in reset");
    end

  // no pulse in the four cycles before a pulse
  a_run_gap_min: assert property (@(posedge clk) disable iff (!sys_resetn)
    i_nes_run |-> !$past(i_nes_run, 1) && !$past(i_nes_run, 2) &&
                  !$past(i_nes_run, 3) && !$past(i_nes_run, 4))
    else begin
      fail_count++;
      $error("run pulses closer than five cycles");
    end

  a_run_gap_max: assert property (@(posedge clk) disable iff (!sys_resetn)
    ($past(i_nes_run, NUM_PHASES) && !i_nes_reset) |-> i_nes_run)
    else begin
      fail_count++;
      $error("run pulse missing five cycles after the previous one");
    end

endmodule

bind mem_slot_arbiter nes_host_chk u_chk (
  .clk         (clk),
  .sys_resetn  (sys_resetn),
  .i_phase     (phase_q),
  .i_nes_reset (i_nes_reset),
  .i_load_valid(i_load.valid),
  .i_ram_we    (o_ram.we),
  .i_rd_pending(pend_cpu_q || pend_ppu_q),
  .i_nes_run   (o_nes_run)
);

// ==== verification/nes_host_monitor.sv ====
// NES host glue monitor
// compares DUT outputs against the expected values from the testbench
// model, measures the run pulse spacing and reports each test
`timescale 1ns/1ps

module nes_host_monitor import nes_host_pkg::*; (
  input  logic              clk,
  input  logic              sys_resetn,
  input  logic [DATA_W-1:0] i_cpu_rdata,
  input  logic [DATA_W-1:0] i_ppu_rdata,
  input  logic [1:0]        i_joy_data,
  input  logic              i_nes_run,
  input  logic              i_nes_reset,
  input  logic              i_chk_valid,
  input  logic [2:0]        i_chk_sel,
  input  logic [DATA_W-1:0] i_chk_exp,
  input  logic              i_test_done,
  input  logic [2:0]        i_test_id,
  output int                o_checks,
  output int                o_errors
);

  int         test_checks = 0;
  int         test_errors = 0;
  int         run_gap     = 0;
  logic       run_seen    = 1'b0;
  logic [7:0] actual;

  initial begin
    o_checks = 0;
    o_errors = 0;
  end

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd1:    return "reset_state";
      3'd2:    return "loader_stream";
      3'd3:    return "nes_write_read";
      3'd4:    return "loader_rewind";
      default: return "joypads";
    endcase
  endfunction

  function automatic string out_name(input logic [2:0] sel);
    case (sel)
      3'd0:    return "o_cpu_rdata";
      3'd1:    return "o_ppu_rdata";
      3'd2:    return "o_joy_data[0]";
      3'd3:    return "o_joy_data[1]";
      3'd4:    return "o_nes_reset";
      default: return "o_nes_run";
    endcase
  endfunction

  task automatic count(input logic ok);
    test_checks++;
    o_checks++;
    if (!ok) begin
      test_errors++;
      o_errors++;
    end
  endtask

  // outputs settle well before the falling edge
  always @(negedge clk) begin
    case (i_chk_sel)
      3'd0:    actual = i_cpu_rdata;
      3'd1:    actual = i_ppu_rdata;
      3'd2:    actual = {7'b0, i_joy_data[0]};
      3'd3:    actual = {7'b0, i_joy_data[1]};
      3'd4:    actual = {7'b0, i_nes_reset};
      default: actual = {7'b0, i_nes_run};
    endcase
    if (i_chk_valid) begin
      count(actual === i_chk_exp);
      if (actual !== i_chk_exp)
        $display("Mismatch in %s on %s: expected %h, actual %h",
                 test_name(i_test_id), out_name(i_chk_sel), i_chk_exp, actual);
    end

    // run pulses every NUM_PHASES cycles out of reset
    if (!sys_resetn || i_nes_reset) begin
      run_seen = 1'b0;
    end else begin
      run_gap++;
      if (i_nes_run) begin
        if (run_seen) begin
          count(run_gap == NUM_PHASES);
          if (run_gap != NUM_PHASES)
            $display("Mismatch in %s on run spacing: expected %0d, actual %0d",
                     test_name(i_test_id), NUM_PHASES, run_gap);
        end
        run_seen = 1'b1;
        run_gap  = 0;
      end
    end

    if (i_test_done) begin
      $display("test %s: %s, %0d checks, %0d errors", test_name(i_test_id),
               (test_errors == 0) ? "pass" : "fail", test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
  end

endmodule

// ==== verification/tb_nes_host.sv ====
// NES host glue testbench
// seeded random host, loader, NES and joypad stimulus checked against
// a byte-array model of the work RAM and the host registers
`timescale 1ns/1ps

module tb_nes_host import nes_host_pkg::*; ();

  localparam logic [2:0] SEL_CPU   = 3'd0; // output codes shared with the monitor
  localparam logic [2:0] SEL_PPU   = 3'd1;
  localparam logic [2:0] SEL_JOY0  = 3'd2;
  localparam logic [2:0] SEL_JOY1  = 3'd3;
  localparam logic [2:0] SEL_RESET = 3'd4;
  localparam logic [2:0] SEL_RUN   = 3'd5;

  localparam int N_READS       = 24;
  localparam int N_RW          = 16;
  localparam int JOY_ROUNDS    = 3;
  localparam int ACCESS_CYCLES = 2 * NUM_PHASES + 3; // two run waits plus checks
  localparam int TEST_CYCLES   = 16 + 64 + 6 * NUM_PHASES + 70 + N_READS * ACCESS_CYCLES
                               + N_RW * (2 * ACCESS_CYCLES + 2) + 20 + 9 * ACCESS_CYCLES
                               + JOY_ROUNDS * 70;
  localparam int MAX_CYCLES    = 2 * TEST_CYCLES;

  logic              clk;
  logic              sys_resetn;
  reg_write_t        host_reg;
  mem_req_t          nes_req;
  nes_buttons_t      pad_btn [2];
  logic              joy_strobe;
  logic [1:0]        joy_clock;
  logic [1:0]        joy_data;
  logic              nes_run;
  logic              nes_reset;
  logic [DATA_W-1:0] cpu_rdata;
  logic [DATA_W-1:0] ppu_rdata;

  logic              chk_valid;
  logic [2:0]        chk_sel;
  logic [DATA_W-1:0] chk_exp;
  logic              test_done;
  logic [2:0]        test_id;
  int                checks;
  int                errors;

  // reference model
  logic [DATA_W-1:0]     ram_model [2**RAM_ADDR_W]; // aliases mod 1024
  logic [MEM_ADDR_W-1:0] load_addr;
  logic                  conf_reset;
  logic [DATA_W-1:0]     btn_model [2];
  logic [DATA_W-1:0]     last_cpu;
  logic [DATA_W-1:0]     last_ppu;
  integer                seed;
  int                    cycles = 0;

  nes_host_top uut (
    .clk         (clk),
    .sys_resetn  (sys_resetn),
    .i_reg       (host_reg),
    .i_nes_req   (nes_req),
    .i_pad_btn0  (pad_btn[0]),
    .i_pad_btn1  (pad_btn[1]),
    .i_joy_strobe(joy_strobe),
    .i_joy_clock (joy_clock),
    .o_joy_data  (joy_data),
    .o_nes_run   (nes_run),
    .o_nes_reset (nes_reset),
    .o_cpu_rdata (cpu_rdata),
    .o_ppu_rdata (ppu_rdata)
  );

  nes_host_monitor mon (
    .clk        (clk),
    .sys_resetn (sys_resetn),
    .i_cpu_rdata(cpu_rdata),
    .i_ppu_rdata(ppu_rdata),
    .i_joy_data (joy_data),
    .i_nes_run  (nes_run),
    .i_nes_reset(nes_reset),
    .i_chk_valid(chk_valid),
    .i_chk_sel  (chk_sel),
    .i_chk_exp  (chk_exp),
    .i_test_done(test_done),
    .i_test_id  (test_id),
    .o_checks   (checks),
    .o_errors   (errors)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles == MAX_CYCLES) begin
      $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // host register write, the model follows the same rules
  task automatic reg_write(input logic [7:0] addr, input logic [DATA_W-1:0] data);
    host_reg = '{strobe: 1'b1, addr: addr, data: data};
    if (addr == REG_CONF) begin
      if (data[CONF_RESET_BIT] && !conf_reset)
        load_addr = '0; // stream restarts
      conf_reset = data[CONF_RESET_BIT];
    end else if (addr == REG_LOAD) begin
      ram_model[load_addr[RAM_ADDR_W-1:0]] = data;
      load_addr = load_addr + 1'b1;
    end else if (addr == REG_BTN0) begin
      btn_model[0] = data;
    end else if (addr == REG_BTN1) begin
      btn_model[1] = data;
    end
    @(posedge clk);
    #2;
    host_reg.strobe = 1'b0;
  endtask

  task automatic expect_out(input logic [2:0] sel, input logic [DATA_W-1:0] exp);
    chk_valid = 1'b1;
    chk_sel   = sel;
    chk_exp   = exp;
    @(posedge clk);
    #2;
    chk_valid = 1'b0;
  endtask

  task automatic end_test();
    test_done = 1'b1;
    @(posedge clk);
    #2;
    test_done = 1'b0;
  endtask

  task automatic wait_run();
    @(negedge clk);
    while (!nes_run)
      @(negedge clk);
  endtask

  // request held from one run pulse to the next, sampled once at phase 0
  task automatic nes_access(input mem_req_t req);
    wait_run();
    @(posedge clk);
    #2;
    nes_req = req;
    wait_run();
    @(posedge clk);
    #2;
    nes_req = '0;
  endtask

  task automatic nes_write(input logic [MEM_ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    nes_access('{rd_cpu: 1'b0, rd_ppu: 1'b0, wr: 1'b1, addr: addr, wdata: data});
    ram_model[addr[RAM_ADDR_W-1:0]] = data;
  endtask

  task automatic nes_read(input logic [MEM_ADDR_W-1:0] addr, input logic rd_cpu,
                          input logic rd_ppu);
    nes_access('{rd_cpu: rd_cpu, rd_ppu: rd_ppu, wr: 1'b0, addr: addr, wdata: 8'h00});
    if (rd_cpu)
      last_cpu = ram_model[addr[RAM_ADDR_W-1:0]]; // cpu wins over ppu
    else if (rd_ppu)
      last_ppu = ram_model[addr[RAM_ADDR_W-1:0]];
    expect_out(SEL_CPU, last_cpu);
    expect_out(SEL_PPU, last_ppu);
  endtask

  // bit k of the merged byte after k falling edges, zeros past bit 7
  task automatic shift_port(input logic port);
    logic [DATA_W-1:0] merged;
    logic [2:0]        sel;
    merged = btn_model[port] | pad_btn[port];
    sel    = port ? SEL_JOY1 : SEL_JOY0;
    for (int k = 0; k <= 10; k++) begin
      if (k > 0) begin
        joy_clock[port] = 1'b1;
        @(posedge clk);
        #2;
        joy_clock[port] = 1'b0;
        @(posedge clk);
        #2;
      end
      expect_out(sel, (merged >> k) & 8'h01);
    end
  endtask

  initial begin
    logic [MEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     data;
    seed       = 51;
    sys_resetn = 1'b0;
    host_reg   = '0;
    nes_req    = '0;
    pad_btn[0] = '0;
    pad_btn[1] = '0;
    joy_strobe = 1'b0;
    joy_clock  = 2'b00;
    chk_valid  = 1'b0;
    chk_sel    = '0;
    chk_exp    = '0;
    test_done  = 1'b0;
    test_id    = 3'd1;
    load_addr  = '0;
    conf_reset = 1'b1; // config resets to 0x01
    btn_model[0] = '0;
    btn_model[1] = '0;
    last_cpu   = '0;
    last_ppu   = '0;
    repeat (16) @(posedge clk);
    #2;
    sys_resetn = 1'b1;

    // reset state, a held NES request must not reach the RAM
    nes_req = '{rd_cpu: 1'b1, rd_ppu: 1'b1, wr: 1'b1,
                addr: MEM_ADDR_W'($random(seed)), wdata: 8'($random(seed))};
    for (int i = 0; i < 50; i++)
      expect_out(SEL_RUN, 8'h00);
    nes_req = '0;
    expect_out(SEL_RESET, 8'h01);
    expect_out(SEL_CPU, 8'h00);
    expect_out(SEL_PPU, 8'h00);
    expect_out(SEL_JOY0, 8'h00);
    expect_out(SEL_JOY1, 8'h00);
    reg_write(REG_CONF, 8'h00);
    expect_out(SEL_RESET, 8'h00);
    repeat (6) wait_run(); // monitor measures the spacing
    @(posedge clk);
    #2;
    end_test();

    test_id = 3'd2;
    reg_write(REG_CONF, 8'h01);
    for (int i = 0; i < 64; i++)
      reg_write(REG_LOAD, 8'($random(seed)));
    reg_write(REG_CONF, 8'h00);
    for (int i = 0; i < N_READS; i++) begin
      addr = MEM_ADDR_W'($random(seed));
      addr[RAM_ADDR_W-1:6] = '0; // upper bits alias onto 0..63
      nes_read(addr, 1'b1, 1'($random(seed)));
    end
    end_test();

    test_id = 3'd3;
    for (int i = 0; i < N_RW; i++) begin
      addr = MEM_ADDR_W'($random(seed));
      data = 8'($random(seed));
      nes_write(addr, data);
      nes_read(addr, 1'b0, 1'b1);
    end
    end_test();

    test_id = 3'd4;
    reg_write(REG_CONF, 8'h01);
    for (int i = 0; i < 8; i++)
      reg_write(REG_LOAD, 8'($random(seed)));
    reg_write(REG_CONF, 8'h00);
    for (int i = 0; i <= 8; i++)
      nes_read(MEM_ADDR_W'(i), 1'b1, 1'b0);
    end_test();

    test_id = 3'd5;
    for (int r = 0; r < JOY_ROUNDS; r++) begin
      reg_write(REG_BTN0, 8'($random(seed)));
      reg_write(REG_BTN1, 8'($random(seed)));
      pad_btn[0] = nes_buttons_t'(8'($random(seed)));
      pad_btn[1] = nes_buttons_t'(8'($random(seed)));
      joy_strobe = 1'b1;
      @(posedge clk);
      #2;
      joy_strobe = 1'b0;
      shift_port(1'b0);
      expect_out(SEL_JOY1, {7'b0, btn_model[1][0] | pad_btn[1].a}); // untouched
      shift_port(1'b1);
    end
    end_test();

    $display("summary: %0d checks, %0d errors, %0d assertion failures", checks, errors,
             uut.u_arb.u_chk.fail_count);
    if (errors == 0 && uut.u_arb.u_chk.fail_count == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule
